/* flist.f */
logic/dso_cfg_pkg.sv
logic/dso_video_pkg.sv
logic/dso_apb_regs.sv
logic/video_pos_track.sv
logic/trace_render.sv
logic/overlay_mix.sv
logic/dso_scope_overlay.sv
sim/dso_overlay_props.sv
sim/tb_dso_scope_overlay.sv

/* Makefile */
TOP := tb_dso_scope_overlay

.PHONY: run lint clean

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

obj_dir/V$(TOP): flist.f $(shell cat flist.f)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

lint:
	verilator --lint-only -Wall --top-module dso_scope_overlay $(shell grep '^logic/' flist.f)

clean:
	rm -rf obj_dir

/* sim/tb_dso_scope_overlay.sv */
module tb_dso_scope_overlay import dso_cfg_pkg::*, dso_video_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int LINE_LEN    = 56;  // 2 hs, 2 back porch, 48 active, 4 front porch
  localparam int FRAME_LINES = 44;  // line 0 carries vs, lines 2 to 41 active
  localparam int NUM_FRAMES  = 5;   // one per video test
  localparam int PIPE_DEPTH  = 4;   // pixels in flight

  typedef struct packed {
    pixel_t pix;
    logic   done;
  } expect_t;

  logic                                 pclk;
  logic                                 rst_n;
  apb_req_t                             apb_req;
  apb_rsp_t                             apb_rsp;
  pixel_t                               pix_in;
  pixel_t                               pix_out;
  logic [NUM_TRACES-1:0][SAMPLE_AW-1:0] rd_addr;
  sample_word_t [NUM_TRACES-1:0]        rd_data = '0;
  logic                                 frame_done;

  sample_word_t   mem [NUM_TRACES][32];  // sample ram contents
  trace_cfg_arr_t cfg_m;                 // expected register state
  logic [11:0]    trig_m;
  expect_t        exp_q[$];
  int             checks = 0;
  int             errors = 0;
  int             done_cnt = 0;

  dso_scope_overlay u_dso_scope_overlay (
    .i_pclk       (pclk),
    .i_rst_n      (rst_n),
    .i_apb        (apb_req),
    .o_apb        (apb_rsp),
    .i_pix        (pix_in),
    .o_pix        (pix_out),
    .o_rd_addr    (rd_addr),
    .i_rd_data    (rd_data),
    .o_frame_done (frame_done)
  );

  bind dso_scope_overlay dso_overlay_props u_props (
    .i_pclk       (i_pclk),
    .i_rst_n      (i_rst_n),
    .i_apb_rsp    (o_apb),
    .i_pix        (o_pix),
    .i_frame_done (o_frame_done)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  // synchronous read rams, word one cycle after the address
  always @(posedge pclk) begin
    for (int t = 0; t < NUM_TRACES; t++) rd_data[t] <= mem[t][rd_addr[t]];
  end

  task automatic check_pixel(input pixel_t got, input pixel_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED o_pix got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_apb(input apb_rsp_t got, input apb_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED o_apb got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED o_frame_done got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  function automatic apb_rsp_t rsp_of(logic [31:0] data, logic err);
    apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;  // zero wait slave
    r.pslverr = err;
    return r;
  endfunction

  // screen row of one column of a trace, rows wrap at 4096
  function automatic logic [11:0] level_of(int t, logic [4:0] col);
    sample_word_t w;
    int           off;
    w = mem[t][col];
    if (cfg_m[t].spec_en) return 12'((4095 - int'(w.fft)) / 64);
    off = 127 - int'(w.adc.code);  // inverted code minus 128
    if (cfg_m[t].scale.up) off = off * (1 << cfg_m[t].scale.sh);
    else off = off >>> cfg_m[t].scale.sh;  // rounds toward minus infinity
    return 12'(int'(WIN_CENTER) + off);
  endfunction

  function automatic expect_t ref_pixel(pixel_t p, logic [11:0] x, logic [11:0] y);
    expect_t     e;
    logic [11:0] cur;
    logic [11:0] prv;
    logic [4:0]  col;
    logic        covered;
    e.pix  = p;
    e.done = p.de && (x == WIN_X1) && (y == WIN_Y1);  // bottom-right window pixel
    if (!(p.de && x >= WIN_X0 && x <= WIN_X1 && y >= WIN_Y0 && y <= WIN_Y1)) return e;
    col     = 5'(x - WIN_X0);
    covered = 1'b0;
    for (int t = 0; t < NUM_TRACES && !covered; t++) begin
      cur = level_of(t, col);
      prv = (col == 5'd0) ? cur : level_of(t, col - 5'd1);  // no segment into column 0
      if ((y >= cur && y <= prv) || (y >= prv && y <= cur)) begin
        e.pix.rgb = cfg_m[t].color;  // lowest index first
        covered   = 1'b1;
      end
    end
    if (!covered && y == trig_m) e.pix.rgb = TRIG_COLOR;
    return e;
  endfunction

  // register word as the map packs it
  function automatic logic [31:0] reg_value(logic [5:0] word);
    case (word)
      REG_CTRL:   return {30'd0, cfg_m[1].spec_en, cfg_m[0].spec_en};
      REG_TRIG:   return {20'd0, trig_m};
      REG_COLOR0: return {8'd0, cfg_m[0].color};
      REG_COLOR1: return {8'd0, cfg_m[1].color};
      REG_SCALE0: return {29'd0, cfg_m[0].scale};
      REG_SCALE1: return {29'd0, cfg_m[1].scale};
      default:    return 32'd0;
    endcase
  endfunction

  // one pclk: drive stream and bus, queue the expected output
  task automatic step(input pixel_t p, input apb_req_t a, input logic [11:0] x,
                      input logic [11:0] y);
    @(posedge pclk);
    #5;
    pix_in  = p;
    apb_req = a;
    exp_q.push_back(ref_pixel(p, x, y));
  endtask

  task automatic apb_xfer(input logic wr, input logic [5:0] word, input logic [31:0] data,
                          output apb_rsp_t rsp);
    apb_req_t a;
    a = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: {word, 2'b00}, pwdata: data};
    step('0, a, '0, '0);  // setup
    a.penable = 1'b1;
    step('0, a, '0, '0);  // access
    @(negedge pclk);
    rsp = apb_rsp;        // read data valid in the access phase
  endtask

  task automatic configure(input logic [1:0] spec, input logic [11:0] trig,
                           input logic [23:0] c0, input logic [23:0] c1,
                           input logic [2:0] s0, input logic [2:0] s1);
    apb_rsp_t r;
    cfg_m[0] = '{color: c0, scale: s0, spec_en: spec[0]};
    cfg_m[1] = '{color: c1, scale: s1, spec_en: spec[1]};
    trig_m   = trig;
    for (int w = 0; w < 6; w++) apb_xfer(1'b1, 6'(w), reg_value(6'(w)), r);  // ctrl..scale1
  endtask

  task automatic readback_all();
    apb_rsp_t r;
    for (int w = 0; w < 6; w++) begin
      apb_xfer(1'b0, 6'(w), 32'd0, r);
      check_apb(r, rsp_of(reg_value(6'(w)), 1'b0));
    end
  endtask

  task automatic run_frame();
    pixel_t      p;
    logic [11:0] x;
    for (int ln = 0; ln < FRAME_LINES; ln++) begin
      x = '0;  // hs rise restarts the columns
      for (int c = 0; c < LINE_LEN; c++) begin
        p.hs  = (c < 2);
        p.vs  = (ln == 0);  // vs rise with the first hs rise, row 0
        p.de  = (ln >= 2) && (ln < 42) && (c >= 4) && (c < 52);
        p.rgb = 24'($urandom);  // background
        step(p, '0, x, 12'(ln));
        if (p.de) x = x + 12'd1;
      end
    end
  endtask

  task automatic report(input string name, input int err0);
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
  endtask

  // mid-cycle sample against the entry queued 4 pixels back
  initial begin : compare
    expect_t e;
    forever begin
      @(negedge pclk);
      if (exp_q.size() > PIPE_DEPTH) begin
        e = exp_q.pop_front();
        check_pixel(pix_out, e.pix);
        check_done(frame_done, e.done);
        if (frame_done) done_cnt++;
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * (NUM_FRAMES * LINE_LEN * FRAME_LINES + 1000));
    $display("timeout, run exceeded %0d frames plus margin", NUM_FRAMES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int       e0;
    int       d0;
    apb_rsp_t r;
    void'($urandom(32620));
    pix_in  = '0;
    apb_req = '0;
    cfg_m   = '0;
    trig_m  = '0;
    rst_n   = 1'b0;
    for (int t = 0; t < NUM_TRACES; t++) begin
      for (int a = 0; a < 32; a++) mem[t][a] = 12'($urandom);
    end
    repeat (2) @(posedge pclk);
    #5;
    rst_n = 1'b1;

    e0 = errors;
    configure(2'b10, 12'h5a5, 24'hc0ffee, 24'h3c5a96, 3'b110, 3'b011);
    readback_all();
    apb_xfer(1'b1, 6'd6, 32'hffff_ffff, r);  // first word past the map
    check_apb(r, rsp_of(32'd0, 1'b1));
    apb_xfer(1'b1, 6'd63, 32'h0000_0007, r);
    check_apb(r, rsp_of(32'd0, 1'b1));
    apb_xfer(1'b0, 6'd9, 32'd0, r);
    check_apb(r, rsp_of(32'd0, 1'b1));
    readback_all();  // map untouched
    report("apb register access", e0);

    e0 = errors;
    configure(2'b00, 12'd0, 24'hff0000, 24'h00ff00, 3'b000, 3'b000);
    run_frame();
    report("time mode unit scale", e0);

    e0 = errors;
    configure(2'b00, 12'd0, 24'hff0000, 24'h00ff00, 3'b101, 3'b010);  // x2 and /4
    run_frame();
    report("time mode gain and attenuation", e0);

    e0 = errors;
    mem[1] = mem[0];  // same words, two views
    configure(2'b01, 12'd0, 24'hffff00, 24'h00ffff, 3'b000, 3'b000);
    run_frame();
    report("spectrum and time views", e0);

    e0 = errors;
    configure(2'b00, 12'd12, 24'hff00ff, 24'h00ff00, 3'b001, 3'b100);
    run_frame();
    report("trigger line", e0);

    e0 = errors;
    d0 = done_cnt;
    configure(2'b11, 12'd35, 24'hffffff, 24'h808080, 3'b111, 3'b000);  // trigger on last row
    run_frame();
    if (done_cnt - d0 != 1) begin
      errors++;
      $display("frame done pulsed %0d times in one frame instead of once", done_cnt - d0);
    end
    report("frame pacing", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  end

endmodule

/* sim/dso_overlay_props.sv */
module dso_overlay_props import dso_cfg_pkg::*, dso_video_pkg::*; (
  input logic     i_pclk,
  input logic     i_rst_n,
  input apb_rsp_t i_apb_rsp,
  input pixel_t   i_pix,         // output stream of the overlay
  input logic     i_frame_done
);

  // zero wait slave
  a_pready_high: assert property (@(posedge i_pclk) disable iff (!i_rst_n)
    i_apb_rsp.pready)
    else $error("pready low outside reset");

  // pipeline still empty as reset lets go
  a_de_quiet: assert property (@(posedge i_pclk)
    $rose(i_rst_n) |-> !i_pix.de ##1 !i_pix.de ##1 !i_pix.de)
    else $error("output de high right after reset");

  a_done_pulse: assert property (@(posedge i_pclk) disable iff (!i_rst_n)
    i_frame_done |=> !i_frame_done)  // single cycle per frame
    else $error("frame done held longer than one cycle");

endmodule

/* logic/dso_scope_overlay.sv */
module dso_scope_overlay import dso_cfg_pkg::*, dso_video_pkg::*; (
  input  logic                                 i_pclk,
  input  logic                                 i_rst_n,
  input  apb_req_t                             i_apb,
  output apb_rsp_t                             o_apb,
  input  pixel_t                               i_pix,
  output pixel_t                               o_pix,
  output logic [NUM_TRACES-1:0][SAMPLE_AW-1:0] o_rd_addr,
  input  sample_word_t [NUM_TRACES-1:0]        i_rd_data,
  output logic                                 o_frame_done
);

  trace_cfg_arr_t        trace_cfg;
  logic [11:0]           trig_line;
  pixel_t                trk_pix;  // tracker out, 1 cycle
  pos_t                  trk_pos;
  hit_t [NUM_TRACES-1:0] hits;     // renderer verdicts, 3 cycles

  dso_apb_regs u_regs (
    .i_pclk      (i_pclk),
    .i_rst_n     (i_rst_n),
    .i_apb       (i_apb),
    .o_apb       (o_apb),
    .o_trace_cfg (trace_cfg),
    .o_trig_line (trig_line)
  );

  video_pos_track u_track (
    .i_pclk  (i_pclk),
    .i_rst_n (i_rst_n),
    .i_pix   (i_pix),
    .o_pix   (trk_pix),
    .o_pos   (trk_pos)
  );

  // one renderer per sample ram
  for (genvar g = 0; g < NUM_TRACES; g++) begin : g_trace
    trace_render u_render (
      .i_pclk      (i_pclk),
      .i_rst_n     (i_rst_n),
      .i_pix       (trk_pix),
      .i_pos       (trk_pos),
      .i_cfg       (trace_cfg[g]),
      .i_trig_line (trig_line),
      .o_rd_addr   (o_rd_addr[g]),
      .i_rd_data   (i_rd_data[g]),
      .o_hit       (hits[g])
    );
  end

  overlay_mix u_mix (
    .i_pclk       (i_pclk),
    .i_rst_n      (i_rst_n),
    .i_pix        (trk_pix),  // realigned inside the mixer
    .i_hits       (hits),
    .o_pix        (o_pix),
    .o_frame_done (o_frame_done)
  );

endmodule

/* logic/overlay_mix.sv */
module overlay_mix import dso_cfg_pkg::*, dso_video_pkg::*; (
  input  logic                  i_pclk,
  input  logic                  i_rst_n,
  input  pixel_t                i_pix,
  input  hit_t [NUM_TRACES-1:0] i_hits,
  output pixel_t                o_pix,
  output logic                  o_frame_done
);

  pixel_t pix_d1, pix_d2;  // matches renderer latency
  pixel_t mix_pix;
  pos_t   cnt_q;
  pos_t   pos_now;         // position of pix_d2
  logic   last_px;

  // lowest index wave wins, trigger row only where no wave
  always_comb begin
    logic wave_any;
    logic trig_any;
    mix_pix  = pix_d2;
    wave_any = 1'b0;
    trig_any = 1'b0;
    for (int i = NUM_TRACES - 1; i >= 0; i--) begin
      if (i_hits[i].wave) begin
        mix_pix.rgb = i_hits[i].color;  // later pass = lower index
        wave_any    = 1'b1;
      end
      trig_any = trig_any | i_hits[i].trig;
    end
    if (!wave_any && trig_any) mix_pix.rgb = TRIG_COLOR;
  end

  // o_pix still holds the syncs of the pixel before pix_d2
  assign pos_now = pix_pos(o_pix, pix_d2, cnt_q);
  assign last_px = pix_d2.de && (pos_now.x == WIN_X1) && (pos_now.y == WIN_Y1);

  always_ff @(posedge i_pclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pix_d1       <= '0;
      pix_d2       <= '0;
      o_pix        <= '0;
      cnt_q        <= '0;
      o_frame_done <= 1'b0;
    end else begin
      pix_d1       <= i_pix;
      pix_d2       <= pix_d1;
      o_pix        <= mix_pix;
      cnt_q.x      <= pos_now.x + {11'd0, pix_d2.de};
      cnt_q.y      <= pos_now.y;
      o_frame_done <= last_px;  // with the bottom-right output pixel
    end
  end

endmodule

/* logic/trace_render.sv */
module trace_render import dso_cfg_pkg::*, dso_video_pkg::*; (
  input  logic                 i_pclk,
  input  logic                 i_rst_n,
  input  pixel_t               i_pix,
  input  pos_t                 i_pos,
  input  trace_cfg_t           i_cfg,
  input  logic [11:0]          i_trig_line,
  output logic [SAMPLE_AW-1:0] o_rd_addr,
  input  sample_word_t         i_rd_data,
  output hit_t                 o_hit
);

  logic        in_win;
  logic [11:0] col;  // column inside window
  logic        win_a, win_b;
  logic        first_a, first_b;  // leftmost window column
  logic [11:0] y_a, y_b;

  logic [11:0]        lvl_spec, lvl_time, lvl_cur, lvl_prev;
  logic [11:0]        lvl_lo, lvl_hi, prev_q;
  logic signed [12:0] off, off_sc;  // distance from code 128

  assign in_win = i_pix.de &&
                  (i_pos.x >= WIN_X0) && (i_pos.x <= WIN_X1) &&
                  (i_pos.y >= WIN_Y0) && (i_pos.y <= WIN_Y1);
  assign col = i_pos.x - WIN_X0;

  // address goes out in stage a and the ram word comes back in stage b
  always_ff @(posedge i_pclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rd_addr <= '0;
      win_a     <= 1'b0;
      win_b     <= 1'b0;
      first_a   <= 1'b0;
      first_b   <= 1'b0;
    end else begin
      o_rd_addr <= in_win ? col[SAMPLE_AW-1:0] : '0;
      win_a     <= in_win;
      win_b     <= win_a;
      first_a   <= in_win && (i_pos.x == WIN_X0);
      first_b   <= first_a;
    end
  end

  always_ff @(posedge i_pclk) begin
    y_a <= i_pos.y;  // row travels with the pixel
    y_b <= y_a;
  end

  // larger fft magnitude sits higher on screen
  assign lvl_spec = (12'd4095 - i_rd_data.fft) >> 6;

  // inverted adc code scaled around 128 and placed on the baseline
  assign off    = $signed({5'd0, 8'd255 - i_rd_data.adc.code}) - 13'sd128;
  assign off_sc = i_cfg.scale.up ? (off <<< i_cfg.scale.sh) : (off >>> i_cfg.scale.sh);
  assign lvl_time = WIN_CENTER + off_sc[11:0];  // wraps mod 4096

  assign lvl_cur  = i_cfg.spec_en ? lvl_spec : lvl_time;
  assign lvl_prev = first_b ? lvl_cur : prev_q;  // no segment into column 0
  assign lvl_lo   = (lvl_prev < lvl_cur) ? lvl_prev : lvl_cur;
  assign lvl_hi   = (lvl_prev < lvl_cur) ? lvl_cur : lvl_prev;

  always_ff @(posedge i_pclk or negedge i_rst_n) begin
    if (!i_rst_n) prev_q <= '0;
    else if (win_b) prev_q <= lvl_cur;  // level of the column just drawn
  end

  // stage b verdict that the mixer registers
  assign o_hit.wave  = win_b && (y_b >= lvl_lo) && (y_b <= lvl_hi);
  assign o_hit.trig  = win_b && (y_b == i_trig_line);
  assign o_hit.color = i_cfg.color;

endmodule

/* logic/video_pos_track.sv */
module video_pos_track import dso_video_pkg::*; (
  input  logic   i_pclk,
  input  logic   i_rst_n,
  input  pixel_t i_pix,
  output pixel_t o_pix,
  output pos_t   o_pos
);

  pixel_t pix_q;    // also the previous sample for edge detect
  pos_t   cnt_q;    // running column / row count
  pos_t   pos_now;  // position of the incoming pixel

  // hs rise restarts x and bumps y, vs rise restarts y
  assign pos_now = pix_pos(pix_q, i_pix, cnt_q);

  always_ff @(posedge i_pclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pix_q <= '0;
      cnt_q <= '0;
      o_pos <= '0;
    end else begin
      pix_q   <= i_pix;
      o_pos   <= pos_now;                       // travels with pix_q
      cnt_q.x <= pos_now.x + {11'd0, i_pix.de}; // only active pixels count
      cnt_q.y <= pos_now.y;
    end
  end

  assign o_pix = pix_q;

endmodule

/* logic/dso_apb_regs.sv */
module dso_apb_regs import dso_cfg_pkg::*; (
  input  logic           i_pclk,
  input  logic           i_rst_n,
  input  apb_req_t       i_apb,
  output apb_rsp_t       o_apb,
  output trace_cfg_arr_t o_trace_cfg,
  output logic [11:0]    o_trig_line
);

  trace_cfg_arr_t cfg_q;
  logic [11:0]    trig_q;
  logic [5:0]     word;     // word address
  logic           access;   // apb access phase
  logic           mapped;
  logic [31:0]    rdata;

  assign word   = i_apb.paddr[7:2];  // byte lanes ignored
  assign access = i_apb.psel & i_apb.penable;

  // read mux, also serves as the address decoder
  always_comb begin
    rdata  = '0;
    mapped = 1'b1;
    case (word)
      REG_CTRL: begin
        for (int i = 0; i < NUM_TRACES; i++) rdata[i] = cfg_q[i].spec_en;
      end
      REG_TRIG:   rdata[11:0] = trig_q;
      REG_COLOR0: rdata[23:0] = cfg_q[0].color;
      REG_COLOR1: rdata[23:0] = cfg_q[1].color;
      REG_SCALE0: rdata[2:0]  = cfg_q[0].scale;
      REG_SCALE1: rdata[2:0]  = cfg_q[1].scale;
      default:    mapped = 1'b0;
    endcase
  end

  always_ff @(posedge i_pclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cfg_q  <= '0;
      trig_q <= '0;
    end else if (access && i_apb.pwrite) begin
      case (word)
        REG_CTRL: begin
          for (int i = 0; i < NUM_TRACES; i++) cfg_q[i].spec_en <= i_apb.pwdata[i];
        end
        REG_TRIG:   trig_q         <= i_apb.pwdata[11:0];
        REG_COLOR0: cfg_q[0].color <= i_apb.pwdata[23:0];
        REG_COLOR1: cfg_q[1].color <= i_apb.pwdata[23:0];
        REG_SCALE0: cfg_q[0].scale <= i_apb.pwdata[2:0];
        REG_SCALE1: cfg_q[1].scale <= i_apb.pwdata[2:0];
        default: ;  // unmapped, nothing written
      endcase
    end
  end

  assign o_apb.prdata  = rdata;                // same access phase
  assign o_apb.pready  = 1'b1;                 // no wait states
  assign o_apb.pslverr = access & ~mapped;
  assign o_trace_cfg   = cfg_q;
  assign o_trig_line   = trig_q;

endmodule

/* logic/dso_video_pkg.sv */
package dso_video_pkg;

  // plot window, inclusive bounds
  localparam logic [11:0] WIN_X0 = 12'd8;
  localparam logic [11:0] WIN_X1 = 12'd39;
  localparam logic [11:0] WIN_Y0 = 12'd4;
  localparam logic [11:0] WIN_Y1 = 12'd35;
  localparam logic [11:0] WIN_CENTER = 12'd20;  // time mode baseline row

  localparam int SAMPLE_AW = 5;  // 32 columns
  localparam logic [23:0] TRIG_COLOR = 24'h0000ff;

  typedef struct packed {
    logic        hs;
    logic        vs;
    logic        de;
    logic [23:0] rgb;
  } pixel_t;

  typedef struct packed {
    logic [11:0] x;
    logic [11:0] y;
  } pos_t;

  // one ram word, read as adc code or as fft magnitude
  typedef union packed {
    struct packed {
      logic [3:0] pad;
      logic [7:0] code;
    } adc;
    logic [11:0] fft;
  } sample_word_t;

  typedef struct packed {
    logic        wave;   // waveform covers pixel
    logic        trig;   // trigger row inside window
    logic [23:0] color;  // trace colour
  } hit_t;

  // position of cur given the previous pixel's syncs and the running count
  function automatic pos_t pix_pos(pixel_t prv, pixel_t cur, pos_t cnt);
    logic hs_rise;
    logic vs_rise;
    pos_t p;
    hs_rise = cur.hs & ~prv.hs;
    vs_rise = cur.vs & ~prv.vs;
    p.x = hs_rise ? 12'd0 : cnt.x;  // new line restarts columns
    if (vs_rise) p.y = 12'd0;
    else if (hs_rise) p.y = cnt.y + 12'd1;
    else p.y = cnt.y;
    return p;
  endfunction

endpackage

/* logic/dso_cfg_pkg.sv */
package dso_cfg_pkg;

  localparam int NUM_TRACES = 2;  // renderer instances

  // apb word offsets, byte address is offset * 4
  localparam logic [5:0] REG_CTRL   = 6'd0;  // spec_en per trace, bit i = trace i
  localparam logic [5:0] REG_TRIG   = 6'd1;  // trigger row [11:0]
  localparam logic [5:0] REG_COLOR0 = 6'd2;  // trace 0 rgb [23:0]
  localparam logic [5:0] REG_COLOR1 = 6'd3;  // trace 1 rgb [23:0]
  localparam logic [5:0] REG_SCALE0 = 6'd4;  // trace 0 {up, shift[1:0]}
  localparam logic [5:0] REG_SCALE1 = 6'd5;  // trace 1 {up, shift[1:0]}

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;   // byte address
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;   // zero wait, tied high
    logic        pslverr;  // unmapped word
  } apb_rsp_t;

  // vertical scale of a time-mode trace
  typedef struct packed {
    logic       up;  // 1 gain up, 0 attenuate
    logic [1:0] sh;  // shift amount
  } scale_t;

  typedef struct packed {
    logic [23:0] color;
    scale_t      scale;
    logic        spec_en;  // fft view instead of adc view
  } trace_cfg_t;

  typedef trace_cfg_t [NUM_TRACES-1:0] trace_cfg_arr_t;

endpackage
